// File: rtl/color_pkg.sv
package color_pkg;

    // one colour channel, also used for hue index and intensity
    typedef logic [7:0] chan_t;

    // full 8x8 product
    typedef logic [15:0] prod_t;

    // mode code as seen on the mode input
    typedef logic [7:0] mode_t;

    // recognised mode codes
    localparam mode_t MODE_PASS = 8'h21;
    localparam mode_t MODE_GEN = 8'ha4;

    // channel limits for saturation
    localparam chan_t CHAN_MAX = 8'hff;
    localparam chan_t CHAN_MIN = 8'h00;

    // ramp defaults, 6 * seg_len must stay within 255
    localparam int DEF_RAMP_STEP = 7;
    localparam int DEF_SEG_LEN = 42;

    // white, red, green, blue, msb first
    typedef struct packed {
        chan_t w;
        chan_t r;
        chan_t g;
        chan_t b;
    } rgbw_t;

    // request from scaler to multiplier
    typedef struct packed {
        logic ld;
        chan_t a;
        chan_t b;
    } mult_req_t;

    // response from multiplier, res valid while ok is high
    typedef struct packed {
        logic ok;
        prod_t res;
    } mult_rsp_t;

endpackage

// File: rtl/hue_ramp_mixer.sv
`timescale 1ns/100ps

module hue_ramp_mixer import color_pkg::*; #(
    parameter int RAMP_STEP = DEF_RAMP_STEP,
    parameter int SEG_LEN = DEF_SEG_LEN
) (
    input logic clk,
    input logic reset,
    input logic start,
    input chan_t hue,
    input chan_t white,
    output logic done,
    output rgbw_t mixed
);

    typedef enum logic [1:0] {
        RAMP_IDLE,
        RAMP_RUN,
        RAMP_MIX
    } ramp_state_e;

    localparam chan_t STEP = chan_t'(RAMP_STEP);
    localparam chan_t MAX_STEPS = chan_t'(6 * SEG_LEN);
    localparam chan_t SEG_LAST = chan_t'(SEG_LEN - 1);

    ramp_state_e state;
    chan_t n_steps;
    chan_t step_cnt;
    chan_t seg_cnt;
    logic [2:0] seg;
    logic stepping;

    function automatic chan_t sat_add(chan_t a, chan_t d);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, d};
        return sum[8] ? CHAN_MAX : sum[7:0];
    endfunction

    function automatic chan_t sat_sub(chan_t a, chan_t d);
        return (a < d) ? CHAN_MIN : chan_t'(a - d);
    endfunction

    // one ramp step per cycle until the capped hue count is reached
    assign stepping = (state == RAMP_RUN) && (step_cnt != n_steps);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= RAMP_IDLE;
            done <= 1'b0;
            step_cnt <= '0;
            seg_cnt <= '0;
            seg <= '0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                RAMP_IDLE:
                begin
                    step_cnt <= '0;
                    seg_cnt <= '0;
                    seg <= '0;
                    if (start)
                        state <= RAMP_RUN;
                end
                RAMP_RUN:
                begin
                    if (stepping)
                    begin
                        step_cnt <= step_cnt + 8'd1;
                        // segment index is step / seg_len, kept as a counter pair
                        if (seg_cnt == SEG_LAST)
                        begin
                            seg_cnt <= '0;
                            seg <= seg + 3'd1;
                        end
                        else
                            seg_cnt <= seg_cnt + 8'd1;
                    end
                    else
                        state <= RAMP_MIX;
                end
                RAMP_MIX:
                begin
                    // white add happens here too
                    done <= 1'b1;
                    state <= RAMP_IDLE;
                end
                default: state <= RAMP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == RAMP_IDLE && start)
        begin
            // cap at six segment lengths
            n_steps <= (hue > MAX_STEPS) ? MAX_STEPS : hue;
            mixed <= '{w: white, r: CHAN_MIN, g: CHAN_MIN, b: CHAN_MIN};
        end
        else if (stepping)
        begin
            case (seg)
                3'd0:
                begin
                    // red full, blue rising
                    mixed.r <= CHAN_MAX;
                    mixed.g <= CHAN_MIN;
                    mixed.b <= sat_add(mixed.b, STEP);
                end
                3'd1:
                begin
                    mixed.b <= CHAN_MAX;
                    mixed.g <= CHAN_MIN;
                    mixed.r <= sat_sub(mixed.r, STEP);
                end
                3'd2:
                begin
                    mixed.r <= CHAN_MIN;
                    mixed.b <= CHAN_MAX;
                    mixed.g <= sat_add(mixed.g, STEP);
                end
                3'd3:
                begin
                    // green full, blue falling
                    mixed.r <= CHAN_MIN;
                    mixed.g <= CHAN_MAX;
                    mixed.b <= sat_sub(mixed.b, STEP);
                end
                3'd4:
                begin
                    mixed.g <= CHAN_MAX;
                    mixed.b <= CHAN_MIN;
                    mixed.r <= sat_add(mixed.r, STEP);
                end
                3'd5:
                begin
                    mixed.r <= CHAN_MAX;
                    mixed.b <= CHAN_MIN;
                    mixed.g <= sat_sub(mixed.g, STEP);
                end
                default:
                begin
                    mixed <= mixed;
                end
            endcase
        end
        else if (state == RAMP_MIX)
        begin
            // lift rgb by the sampled white
            mixed.r <= sat_add(mixed.r, mixed.w);
            mixed.g <= sat_add(mixed.g, mixed.w);
            mixed.b <= sat_add(mixed.b, mixed.w);
        end
    end

endmodule

// File: rtl/shift_add_mult.sv
`timescale 1ns/100ps

module shift_add_mult import color_pkg::*; (
    input logic clk,
    input logic reset,
    input mult_req_t req,
    output mult_rsp_t rsp
);

    typedef enum logic [1:0] {
        MULT_IDLE,
        MULT_RUN,
        MULT_HOLD
    } mult_state_e;

    mult_state_e state;
    logic ok_q;
    logic [2:0] bit_cnt;
    prod_t acc;
    prod_t mcand;
    chan_t mplier;

    assign rsp = '{ok: ok_q, res: acc};

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= MULT_IDLE;
            ok_q <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                MULT_IDLE:
                begin
                    bit_cnt <= '0;
                    if (req.ld)
                        state <= MULT_RUN;
                end
                MULT_RUN:
                begin
                    bit_cnt <= bit_cnt + 3'd1;
                    // last bit lands together with ok
                    if (bit_cnt == 3'd7)
                    begin
                        ok_q <= 1'b1;
                        state <= MULT_HOLD;
                    end
                end
                MULT_HOLD:
                begin
                    // keep result until requester lets go of ld
                    if (!req.ld)
                    begin
                        ok_q <= 1'b0;
                        state <= MULT_IDLE;
                    end
                end
                default: state <= MULT_IDLE;
            endcase
        end
    end

    // one bit of the scanned operand per cycle, lsb first
    always_ff @(posedge clk)
    begin
        if (state == MULT_IDLE && req.ld)
        begin
            acc <= '0;
            mcand <= {8'h00, req.a};
            mplier <= req.b;
        end
        else if (state == MULT_RUN)
        begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

// File: rtl/intensity_scaler.sv
`timescale 1ns/100ps

module intensity_scaler import color_pkg::*; (
    input logic clk,
    input logic reset,
    input logic start,
    input chan_t level,
    input rgbw_t color,
    input mult_rsp_t rsp,
    output mult_req_t req,
    output logic done,
    output rgbw_t scaled
);

    typedef enum logic {
        SCL_IDLE,
        SCL_RUN
    } scl_state_e;

    scl_state_e state;
    logic [1:0] idx;
    logic ld_q;
    logic capture;
    chan_t cur_chan;

    // product order is w, r, g, b
    always_comb
    begin
        case (idx)
            2'd0: cur_chan = color.w;
            2'd1: cur_chan = color.r;
            2'd2: cur_chan = color.g;
            default: cur_chan = color.b;
        endcase
    end

    assign req = '{ld: ld_q, a: level, b: cur_chan};

    // result seen while still requesting
    assign capture = (state == SCL_RUN) && ld_q && rsp.ok;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= SCL_IDLE;
            idx <= '0;
            ld_q <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                SCL_IDLE:
                begin
                    idx <= '0;
                    ld_q <= 1'b0;
                    if (start)
                        state <= SCL_RUN;
                end
                SCL_RUN:
                begin
                    if (capture)
                    begin
                        ld_q <= 1'b0;
                        idx <= idx + 2'd1;
                        if (idx == 2'd3)
                        begin
                            done <= 1'b1;
                            state <= SCL_IDLE;
                        end
                    end
                    else if (!ld_q && !rsp.ok)
                        // previous ok must have dropped first
                        ld_q <= 1'b1;
                end
                default: state <= SCL_IDLE;
            endcase
        end
    end

    // keep the high byte, i.e. product / 256
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            case (idx)
                2'd0: scaled.w <= rsp.res[15:8];
                2'd1: scaled.r <= rsp.res[15:8];
                2'd2: scaled.g <= rsp.res[15:8];
                default: scaled.b <= rsp.res[15:8];
            endcase
        end
    end

endmodule

// File: rtl/color_gen.sv
`timescale 1ns/100ps

module color_gen import color_pkg::*; #(
    parameter int RAMP_STEP = DEF_RAMP_STEP,
    parameter int SEG_LEN = DEF_SEG_LEN
) (
    input logic clk,
    input logic reset,
    input mode_t mode,
    input chan_t color_idx,
    input chan_t intensity,
    input rgbw_t color_in,
    output rgbw_t color_out,
    output logic busy
);

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_MIXING,
        CTRL_SCALING
    } ctrl_state_e;

    ctrl_state_e state;
    mode_t mode_q;
    logic gen_go;
    logic mix_start;
    logic mix_done;
    logic scl_start;
    logic scl_done;
    chan_t hue_q;
    chan_t level_q;
    chan_t white_q;
    rgbw_t mixed;
    rgbw_t scaled;
    mult_req_t mult_req;
    mult_rsp_t mult_rsp;

    // decode only the registered mode
    assign gen_go = (state == CTRL_IDLE) && (mode_q == MODE_GEN);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= CTRL_IDLE;
            mode_q <= '0;
            busy <= 1'b0;
            mix_start <= 1'b0;
            scl_start <= 1'b0;
            color_out <= '0;
        end
        else
        begin
            mode_q <= mode;
            mix_start <= 1'b0;
            scl_start <= 1'b0;
            case (state)
                CTRL_IDLE:
                begin
                    if (mode_q == MODE_PASS)
                        color_out <= color_in;
                    else if (gen_go)
                    begin
                        mix_start <= 1'b1;
                        busy <= 1'b1;
                        state <= CTRL_MIXING;
                    end
                    // any other code holds the output
                end
                CTRL_MIXING:
                begin
                    if (mix_done)
                    begin
                        scl_start <= 1'b1;
                        state <= CTRL_SCALING;
                    end
                end
                CTRL_SCALING:
                begin
                    // result and busy drop on the same edge
                    if (scl_done)
                    begin
                        color_out <= scaled;
                        busy <= 1'b0;
                        state <= CTRL_IDLE;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    // inputs frozen for the whole generate run
    always_ff @(posedge clk)
    begin
        if (gen_go)
        begin
            hue_q <= color_idx;
            level_q <= intensity;
            white_q <= color_in.w;
        end
    end

    hue_ramp_mixer #(
        .RAMP_STEP(RAMP_STEP),
        .SEG_LEN(SEG_LEN)
    ) mixer_i (
        .clk(clk),
        .reset(reset),
        .start(mix_start),
        .hue(hue_q),
        .white(white_q),
        .done(mix_done),
        .mixed(mixed)
    );

    intensity_scaler scaler_i (
        .clk(clk),
        .reset(reset),
        .start(scl_start),
        .level(level_q),
        .color(mixed),
        .rsp(mult_rsp),
        .req(mult_req),
        .done(scl_done),
        .scaled(scaled)
    );

    shift_add_mult mult_i (
        .clk(clk),
        .reset(reset),
        .req(mult_req),
        .rsp(mult_rsp)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter real PERIOD_NS = 4.0,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    // free running clock
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // active low reset, released on a falling edge away from the sampling edge
    initial
    begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
    end

endmodule

// File: tb/color_gen_chk.sv
`timescale 1ns/100ps

module color_gen_chk import color_pkg::*; (
    input logic clk,
    input logic reset,
    input logic busy,
    input rgbw_t color_out,
    input mult_req_t mult_req,
    input mult_rsp_t mult_rsp
);

    // per assertion failure tallies
    int reset_fails = 0;
    int ld_fails = 0;
    int stable_fails = 0;
    int fail_count;

    assign fail_count = reset_fails + ld_fails + stable_fails;

    // busy comes out of reset low
    busy_after_reset: assert property (
        @(posedge clk) $rose(reset) |-> !busy
    ) else
    begin
        $error("busy high in the cycle after reset release");
        reset_fails++;
    end

    // load request only starts once the previous ok has dropped
    ld_rise_ok_low: assert property (
        @(posedge clk) disable iff (!reset)
        $rose(mult_req.ld) |-> !mult_rsp.ok
    ) else
    begin
        $error("multiplier ld rose while ok was high");
        ld_fails++;
    end

    // output register frozen during a generate run
    out_stable_busy: assert property (
        @(posedge clk) disable iff (!reset)
        (busy && $past(busy)) |-> $stable(color_out)
    ) else
    begin
        $error("color_out changed while busy was high");
        stable_fails++;
    end

endmodule

// File: tb/color_gen_tb.sv
`timescale 1ns/100ps

module color_gen_tb import color_pkg::*;;

    localparam int GEN_TIMEOUT = 1000;
    localparam int RESET_TIMEOUT = 50;

    logic clk;
    logic reset;
    mode_t mode;
    chan_t color_idx;
    chan_t intensity;
    rgbw_t color_in;
    rgbw_t color_out;
    logic busy;

    logic [31:0] lfsr_state;
    int test_count;
    int check_count;
    int err_count;

    tb_clock #(
        .PERIOD_NS(4.0),
        .RESET_CYCLES(4)
    ) clock_i (
        .clk(clk),
        .reset(reset)
    );

    color_gen #(
        .RAMP_STEP(DEF_RAMP_STEP),
        .SEG_LEN(DEF_SEG_LEN)
    ) color_gen_i (
        .clk(clk),
        .reset(reset),
        .mode(mode),
        .color_idx(color_idx),
        .intensity(intensity),
        .color_in(color_in),
        .color_out(color_out),
        .busy(busy)
    );

    bind color_gen color_gen_chk chk_i (
        .clk(clk),
        .reset(reset),
        .busy(busy),
        .color_out(color_out),
        .mult_req(mult_req),
        .mult_rsp(mult_rsp)
    );

    // galois lfsr stepped once per bit
    function automatic logic next_rand_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb)
            lfsr_state = lfsr_state ^ 32'h80200003;
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
            val = {val[30:0], next_rand_bit()};
        return val;
    endfunction

    function automatic chan_t clamp_chan(input int v);
        if (v < 0)
            return 8'h00;
        if (v > 255)
            return 8'hff;
        return chan_t'(v);
    endfunction

    // ramp walk, white lift and intensity scaling
    function automatic rgbw_t expected_color(input chan_t hue, input chan_t white,
                                             input chan_t level);
        int r;
        int g;
        int b;
        int steps;
        int seg;
        int lv;
        int wv;
        rgbw_t res;
        r = 0;
        g = 0;
        b = 0;
        lv = level;
        wv = white;
        steps = (hue > 6 * DEF_SEG_LEN) ? 6 * DEF_SEG_LEN : hue;
        for (int k = 0; k < steps; k++)
        begin
            seg = k / DEF_SEG_LEN;
            case (seg)
                0:
                begin
                    r = 255;
                    g = 0;
                    b = clamp_chan(b + DEF_RAMP_STEP);
                end
                1:
                begin
                    b = 255;
                    g = 0;
                    r = clamp_chan(r - DEF_RAMP_STEP);
                end
                2:
                begin
                    r = 0;
                    b = 255;
                    g = clamp_chan(g + DEF_RAMP_STEP);
                end
                3:
                begin
                    r = 0;
                    g = 255;
                    b = clamp_chan(b - DEF_RAMP_STEP);
                end
                4:
                begin
                    g = 255;
                    b = 0;
                    r = clamp_chan(r + DEF_RAMP_STEP);
                end
                default:
                begin
                    r = 255;
                    b = 0;
                    g = clamp_chan(g - DEF_RAMP_STEP);
                end
            endcase
        end
        // white lift with saturation
        r = clamp_chan(r + wv);
        g = clamp_chan(g + wv);
        b = clamp_chan(b + wv);
        // high byte of each product
        res.w = chan_t'((lv * wv) >> 8);
        res.r = chan_t'((lv * r) >> 8);
        res.g = chan_t'((lv * g) >> 8);
        res.b = chan_t'((lv * b) >> 8);
        return res;
    endfunction

    task automatic compare_values(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // bounded wait for busy on falling edges
    task automatic wait_for_busy(input logic level, output logic ok);
        int n;
        n = 0;
        while (busy !== level && n < GEN_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        ok = (busy === level);
        if (!ok)
        begin
            err_count++;
            $display("timeout: busy did not go to %0d within %0d cycles", level, GEN_TIMEOUT);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, err_count - errs_before);
    endtask

    // one full generate run checked against the model
    task automatic run_generate(input chan_t hue, input chan_t white, input chan_t level);
        rgbw_t exp;
        logic ok;
        exp = expected_color(hue, white, level);
        @(negedge clk);
        mode = MODE_GEN;
        color_idx = hue;
        intensity = level;
        color_in = rand_bits(32);
        color_in.w = white;
        wait_for_busy(1'b1, ok);
        if (ok)
        begin
            mode = 8'h00;
            wait_for_busy(1'b0, ok);
            if (ok)
                compare_values("color_out", color_out, exp);
        end
    endtask

    task automatic check_reset_state();
        int errs;
        int n;
        errs = err_count;
        n = 0;
        while (reset !== 1'b1 && n < RESET_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (reset !== 1'b1)
        begin
            err_count++;
            $display("timeout: reset was never released");
        end
        @(negedge clk);
        compare_values("color_out", color_out, 32'h0);
        compare_values("busy", busy, 1'b0);
        report_test("reset", errs);
    endtask

    task automatic run_pass_through();
        int errs;
        errs = err_count;
        for (int i = 0; i < 20; i++)
        begin
            @(negedge clk);
            mode = MODE_PASS;
            color_in = rand_bits(32);
            color_idx = chan_t'(rand_bits(8));
            intensity = chan_t'(rand_bits(8));
            // mode register plus output register
            repeat (2) @(negedge clk);
            compare_values("color_out", color_out, color_in);
            compare_values("busy", busy, 1'b0);
        end
        report_test("pass-through", errs);
    endtask

    task automatic sweep_random_hues();
        int errs;
        chan_t hue;
        chan_t white;
        chan_t level;
        errs = err_count;
        for (int i = 0; i < 40; i++)
        begin
            hue = chan_t'(rand_bits(8));
            white = chan_t'(rand_bits(8));
            level = chan_t'(rand_bits(8));
            run_generate(hue, white, level);
        end
        report_test("random generation", errs);
    endtask

    task automatic cover_hue_corners();
        chan_t hues[8];
        int errs;
        errs = err_count;
        hues = '{8'd0, 8'd1, 8'd41, 8'd42, 8'd126, 8'd251, 8'd252, 8'd255};
        // small white and full intensity keep the ramp visible
        foreach (hues[i])
            run_generate(hues[i], chan_t'(rand_bits(5)), 8'hff);
        report_test("hue corners", errs);
    endtask

    task automatic drive_intensity_extremes();
        int errs;
        chan_t hue;
        chan_t white;
        errs = err_count;
        for (int i = 0; i < 10; i++)
        begin
            hue = chan_t'(rand_bits(8));
            white = chan_t'(rand_bits(8));
            run_generate(hue, white, 8'h00);
            compare_values("color_out", color_out, 32'h0);
        end
        for (int i = 0; i < 10; i++)
        begin
            hue = chan_t'(rand_bits(8));
            white = chan_t'(rand_bits(8));
            run_generate(hue, white, 8'hff);
        end
        report_test("intensity extremes", errs);
    endtask

    task automatic hold_on_other_modes();
        rgbw_t held;
        mode_t other;
        int errs;
        errs = err_count;
        for (int i = 0; i < 5; i++)
        begin
            // known value on the output first
            @(negedge clk);
            mode = MODE_PASS;
            color_in = rand_bits(32);
            repeat (2) @(negedge clk);
            other = mode_t'(rand_bits(8));
            if (other == MODE_PASS || other == MODE_GEN)
                other = other ^ 8'h01;
            mode = other;
            // color_in held until the new mode is registered
            repeat (2) @(negedge clk);
            held = color_out;
            for (int j = 0; j < 8; j++)
            begin
                color_in = rand_bits(32);
                color_idx = chan_t'(rand_bits(8));
                intensity = chan_t'(rand_bits(8));
                @(negedge clk);
                compare_values("color_out", color_out, held);
                compare_values("busy", busy, 1'b0);
            end
        end
        report_test("other modes", errs);
    endtask

    initial
    begin
        lfsr_state = 32'ha09;
        test_count = 0;
        check_count = 0;
        err_count = 0;
        mode = 8'h00;
        color_idx = 8'h00;
        intensity = 8'h00;
        color_in = '0;
        check_reset_state();
        run_pass_through();
        sweep_random_hues();
        cover_hue_corners();
        drive_intensity_extremes();
        hold_on_other_modes();
        // bound assertion failures count as errors too
        err_count += color_gen_i.chk_i.fail_count;
        $display("tests %0d, checks %0d, assertion failures %0d, errors %0d",
                 test_count, check_count, color_gen_i.chk_i.fail_count, err_count);
        if (err_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: flist.f
rtl/color_pkg.sv
rtl/hue_ramp_mixer.sv
rtl/shift_add_mult.sv
rtl/intensity_scaler.sv
rtl/color_gen.sv
tb/tb_clock.sv
tb/color_gen_chk.sv
tb/color_gen_tb.sv
